//--- Makefile
VERILATOR  ?= verilator
TOP        := column_msg_ram_tb
FILE_LIST  := src.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
RUN_FLAGS  := +verilator+error+limit+1000
PASS_MSG   := all tests passed
FAIL_MSG   := tests failed

SOURCES := $(shell cat $(FILE_LIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: build
	./$(SIM_BIN) $(RUN_FLAGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a verdict, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bank_port_if.sv
`timescale 1ns/10ps

interface bank_port_if #(
	parameter type word_t = column_ram_pkg::full_word_t
);

	column_ram_pkg::addr_t addr;
	logic                  we;   // High writes, low reads
	word_t                 din;
	word_t                 dout; // Two edges after addr on a read

	// Lane mapping side
	modport user (
		output addr,
		output we,
		output din,
		input  dout
	);

	// Memory bank side
	modport ram (
		input  addr,
		input  we,
		input  din,
		output dout
	);

endinterface

//--- column_msg_ram.sv
`timescale 1ns/10ps

module column_msg_ram (
	input  logic                      sys_clk,
	input  logic                      rst_n,

	// Port A on the check-node side
	input  column_ram_pkg::addr_t     addr_a,
	input  logic                      we_a,
	input  column_ram_pkg::lane_bus_t din_a,
	output column_ram_pkg::lane_bus_t dout_a,

	// Port B on the variable-node side
	input  column_ram_pkg::addr_t     addr_b,
	input  logic                      we_b,
	input  column_ram_pkg::lane_bus_t din_b,
	output column_ram_pkg::lane_bus_t dout_b
);

	// Full bank k holds lanes 9k to 9k+8
	generate
		for (genvar k = 0; k < column_ram_pkg::full_bank_num; k++) begin : g_full
			bank_port_if #(.word_t(column_ram_pkg::full_word_t)) bank_a ();
			bank_port_if #(.word_t(column_ram_pkg::full_word_t)) bank_b ();

			// Address and enable go to every bank unchanged
			assign bank_a.addr = addr_a;
			assign bank_a.we   = we_a;
			assign bank_b.addr = addr_b;
			assign bank_b.we   = we_b;

			for (genvar j = 0; j < column_ram_pkg::lanes_per_bank; j++) begin : g_lane
				// Lowest lane of the bank in the top slot
				assign bank_a.din[column_ram_pkg::lanes_per_bank-1-j] =
					din_a[k*column_ram_pkg::lanes_per_bank+j];
				assign bank_b.din[column_ram_pkg::lanes_per_bank-1-j] =
					din_b[k*column_ram_pkg::lanes_per_bank+j];

				// And back out in lane order
				assign dout_a[k*column_ram_pkg::lanes_per_bank+j] =
					bank_a.dout[column_ram_pkg::lanes_per_bank-1-j];
				assign dout_b[k*column_ram_pkg::lanes_per_bank+j] =
					bank_b.dout[column_ram_pkg::lanes_per_bank-1-j];
			end

			dp_ram_bank #(
				.word_t (column_ram_pkg::full_word_t)
			) u_bank (
				.sys_clk (sys_clk),
				.rst_n   (rst_n),
				.port_a  (bank_a),
				.port_b  (bank_b)
			);
		end
	endgenerate

	// Fragment bank for the last four lanes
	bank_port_if #(.word_t(column_ram_pkg::frag_word_t)) frag_a ();
	bank_port_if #(.word_t(column_ram_pkg::frag_word_t)) frag_b ();

	assign frag_a.addr = addr_a;
	assign frag_a.we   = we_a;
	assign frag_b.addr = addr_b;
	assign frag_b.we   = we_b;

	generate
		for (genvar j = 0; j < column_ram_pkg::frag_lanes; j++) begin : g_frag_lane
			// Same slot order as the full banks
			assign frag_a.din[column_ram_pkg::frag_lanes-1-j] =
				din_a[column_ram_pkg::frag_lane_base+j];
			assign frag_b.din[column_ram_pkg::frag_lanes-1-j] =
				din_b[column_ram_pkg::frag_lane_base+j];

			assign dout_a[column_ram_pkg::frag_lane_base+j] =
				frag_a.dout[column_ram_pkg::frag_lanes-1-j];
			assign dout_b[column_ram_pkg::frag_lane_base+j] =
				frag_b.dout[column_ram_pkg::frag_lanes-1-j];
		end
	endgenerate

	dp_ram_bank #(
		.word_t (column_ram_pkg::frag_word_t)
	) u_frag_bank (
		.sys_clk (sys_clk),
		.rst_n   (rst_n),
		.port_a  (frag_a),
		.port_b  (frag_b)
	);

endmodule

//--- column_msg_ram_asserts.sv
`timescale 1ns/10ps

module column_msg_ram_asserts (
	input logic                      sys_clk,
	input logic                      rst_n,
	input column_ram_pkg::addr_t     addr_a,
	input column_ram_pkg::addr_t     addr_b,
	input logic                      we_a,
	input logic                      we_b,
	input column_ram_pkg::lane_bus_t din_a,
	input column_ram_pkg::lane_bus_t din_b,
	input column_ram_pkg::lane_bus_t dout_a,
	input column_ram_pkg::lane_bus_t dout_b
);

	int fail_count = 0; // Read by the testbench after each test

	// Shadow of the array written from the sampled inputs
	column_ram_pkg::lane_bus_t            shadow [column_ram_pkg::ram_depth];
	logic [column_ram_pkg::ram_depth-1:0] written; // Addresses with known data

	// Expected dout per port loaded on a read edge
	column_ram_pkg::lane_bus_t exp_a1;
	column_ram_pkg::lane_bus_t exp_a2;
	column_ram_pkg::lane_bus_t exp_b1;
	column_ram_pkg::lane_bus_t exp_b2;
	logic                      known_a1;
	logic                      known_a2;
	logic                      known_b1;
	logic                      known_b2;

	always_ff @(posedge sys_clk) begin
		if (we_a) begin
			shadow[addr_a] <= din_a;
		end
		if (we_b) begin
			shadow[addr_b] <= din_b;
		end
	end

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			written <= '0;
		end else begin
			if (we_a) begin
				written[addr_a] <= 1'b1;
			end
			if (we_b) begin
				written[addr_b] <= 1'b1;
			end
		end
	end

	// Zero after reset counts as known data
	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			exp_a1   <= '0;
			exp_a2   <= '0;
			known_a1 <= 1'b1;
			known_a2 <= 1'b1;
		end else begin
			if (!we_a) begin
				exp_a1   <= shadow[addr_a]; // Old word if B writes here now
				known_a1 <= written[addr_a];
			end
			exp_a2   <= exp_a1;
			known_a2 <= known_a1;
		end
	end

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			exp_b1   <= '0;
			exp_b2   <= '0;
			known_b1 <= 1'b1;
			known_b2 <= 1'b1;
		end else begin
			if (!we_b) begin
				exp_b1   <= shadow[addr_b];
				known_b1 <= written[addr_b];
			end
			exp_b2   <= exp_b1;
			known_b2 <= known_b1;
		end
	end

	read_a_check: assert property (@(posedge sys_clk) disable iff (!rst_n)
		known_a2 |-> dout_a == exp_a2)
	else begin
		$error("[ERROR] %0t port A read data differs from the shadow memory", $time);
		fail_count++;
	end

	read_b_check: assert property (@(posedge sys_clk) disable iff (!rst_n)
		known_b2 |-> dout_b == exp_b2)
	else begin
		$error("[ERROR] %0t port B read data differs from the shadow memory", $time);
		fail_count++;
	end

	// A write two edges back leaves dout where it was
	hold_a_check: assert property (@(posedge sys_clk) disable iff (!rst_n)
		$past(we_a, 2) |-> $stable(dout_a))
	else begin
		$error("[ERROR] %0t port A dout changed while port A was writing", $time);
		fail_count++;
	end

	hold_b_check: assert property (@(posedge sys_clk) disable iff (!rst_n)
		$past(we_b, 2) |-> $stable(dout_b))
	else begin
		$error("[ERROR] %0t port B dout changed while port B was writing", $time);
		fail_count++;
	end

	reset_zero_check: assert property (@(posedge sys_clk)
		(!rst_n && $past(!rst_n)) |-> (dout_a == '0 && dout_b == '0))
	else begin
		$error("[ERROR] %0t dout not zero during reset", $time);
		fail_count++;
	end

endmodule

//--- column_msg_ram_tb.sv
`timescale 1ns/10ps

module column_msg_ram_tb;

	localparam int          test_count     = 6;
	localparam int          reset_cycles   = 3;
	localparam int          drain_cycles   = 3;    // Read latency plus one edge
	localparam int          timeout_cycles = 2000; // Sequence needs about 100 cycles
	localparam int unsigned rand_seed      = 32'hf3bb5c59;

	logic                      sys_clk;
	logic                      rst_n;
	column_ram_pkg::addr_t     addr_a;
	column_ram_pkg::addr_t     addr_b;
	logic                      we_a;
	logic                      we_b;
	column_ram_pkg::lane_bus_t din_a;
	column_ram_pkg::lane_bus_t din_b;
	column_ram_pkg::lane_bus_t dout_a;
	column_ram_pkg::lane_bus_t dout_b;

	int cycle_count = 0;
	int tests_clean = 0;
	int tests_dirty = 0;
	int fails_seen  = 0;

	column_msg_ram column_msg_ram_i (
		.sys_clk (sys_clk),
		.rst_n   (rst_n),
		.addr_a  (addr_a),
		.we_a    (we_a),
		.din_a   (din_a),
		.dout_a  (dout_a),
		.addr_b  (addr_b),
		.we_b    (we_b),
		.din_b   (din_b),
		.dout_b  (dout_b)
	);

	bind column_msg_ram column_msg_ram_asserts asserts_i (
		.sys_clk (sys_clk),
		.rst_n   (rst_n),
		.addr_a  (addr_a),
		.addr_b  (addr_b),
		.we_a    (we_a),
		.we_b    (we_b),
		.din_a   (din_a),
		.din_b   (din_b),
		.dout_a  (dout_a),
		.dout_b  (dout_b)
	);

	always #2 sys_clk = ~sys_clk;

	always @(posedge sys_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("Timeout: run stopped after %0d cycles with tests still running",
				cycle_count);
			$display("tests failed");
			$finish;
		end
	end

	function automatic column_ram_pkg::lane_bus_t random_bus();
		column_ram_pkg::lane_bus_t bus;
		for (int i = 0; i < column_ram_pkg::check_parallelism; i++) begin
			bus[i] = column_ram_pkg::msg_t'($urandom);
		end
		return bus;
	endfunction

	// Lane index bits from shift upward so two words make each lane unique
	function automatic column_ram_pkg::lane_bus_t lane_index_bus(input int shift);
		column_ram_pkg::lane_bus_t bus;
		for (int i = 0; i < column_ram_pkg::check_parallelism; i++) begin
			bus[i] = column_ram_pkg::msg_t'(i >> shift);
		end
		return bus;
	endfunction

	// One clock of stimulus on both ports
	task automatic drive_cycle(
		input logic                      wa,
		input column_ram_pkg::addr_t     aa,
		input column_ram_pkg::lane_bus_t da,
		input logic                      wb,
		input column_ram_pkg::addr_t     ab,
		input column_ram_pkg::lane_bus_t db
	);
		@(posedge sys_clk);
		we_a   <= wa;
		addr_a <= aa;
		din_a  <= da;
		we_b   <= wb;
		addr_b <= ab;
		din_b  <= db;
	endtask

	task automatic report_test(input int num, input string name);
		int fails_now;
		int new_fails;
		repeat (drain_cycles) begin
			drive_cycle(1'b0, addr_a, '0, 1'b0, addr_b, '0);
		end
		@(negedge sys_clk); // Assertion actions of the last edge are done
		fails_now  = column_msg_ram_i.asserts_i.fail_count;
		new_fails  = fails_now - fails_seen;
		fails_seen = fails_now;
		if (new_fails == 0) begin
			tests_clean++;
			$display("test %0d %s: PASS", num, name);
		end else begin
			tests_dirty++;
			$display("test %0d %s: FAIL, %0d assertion failures", num, name, new_fails);
		end
	endtask

	initial begin
		column_ram_pkg::addr_t     addr;
		column_ram_pkg::lane_bus_t data;
		int                        base;

		sys_clk = 1'b0;
		rst_n   = 1'b0;
		we_a    = 1'b0;
		we_b    = 1'b0;
		addr_a  = '0;
		addr_b  = '0;
		din_a   = '0;
		din_b   = '0;
		void'($urandom(rand_seed));

		repeat (reset_cycles) @(posedge sys_clk);
		rst_n <= 1'b1;

		// Address 0 is unwritten so only the reset zeros are known
		repeat (2) begin
			drive_cycle(1'b0, '0, '0, 1'b0, '0, '0);
		end
		report_test(1, "reset zero");

		for (int i = 0; i < 8; i++) begin
			addr = column_ram_pkg::addr_t'($urandom);
			data = random_bus();
			drive_cycle(1'b1, addr, data, 1'b0, addr_b, '0);
			drive_cycle(1'b0, addr, '0, 1'b0, addr, '0);
		end
		report_test(2, "port A write, port B read");

		for (int i = 0; i < 8; i++) begin
			addr = column_ram_pkg::addr_t'($urandom);
			data = random_bus();
			drive_cycle(1'b0, addr_a, '0, 1'b1, addr, data);
			drive_cycle(1'b0, addr, '0, 1'b0, addr, '0);
		end
		report_test(3, "port B write, port A read");

		base = 100;
		for (int i = 0; i < 8; i++) begin
			drive_cycle(1'b1, column_ram_pkg::addr_t'(base + i), random_bus(),
				1'b0, addr_b, '0);
		end
		// New address every cycle on both ports
		for (int i = 0; i < 8; i++) begin
			drive_cycle(1'b0, column_ram_pkg::addr_t'(base + i), '0,
				1'b0, column_ram_pkg::addr_t'(base + 7 - i), '0);
		end
		report_test(4, "back-to-back reads");

		drive_cycle(1'b0, column_ram_pkg::addr_t'(base), '0,
			1'b0, column_ram_pkg::addr_t'(base), '0);
		for (int i = 0; i < 5; i++) begin
			drive_cycle(1'b1, column_ram_pkg::addr_t'(200 + i), random_bus(),
				1'b0, column_ram_pkg::addr_t'(base + 1 + i), '0);
		end
		// B reads the word A overwrites on the same edge
		drive_cycle(1'b1, column_ram_pkg::addr_t'(base + 3), random_bus(),
			1'b0, column_ram_pkg::addr_t'(base + 3), '0);
		drive_cycle(1'b0, column_ram_pkg::addr_t'(base + 3), '0,
			1'b0, column_ram_pkg::addr_t'(base + 3), '0);
		for (int i = 0; i < 4; i++) begin
			drive_cycle(1'b0, column_ram_pkg::addr_t'(200 + i), '0,
				1'b1, column_ram_pkg::addr_t'(300 + i), random_bus());
		end
		for (int i = 0; i < 4; i++) begin
			drive_cycle(1'b0, column_ram_pkg::addr_t'(300 + i), '0,
				1'b0, column_ram_pkg::addr_t'(300 + i), '0);
		end
		report_test(5, "read hold during write");

		drive_cycle(1'b1, column_ram_pkg::addr_t'(900), lane_index_bus(0),
			1'b0, addr_b, '0);
		drive_cycle(1'b1, column_ram_pkg::addr_t'(901), lane_index_bus(4),
			1'b0, addr_b, '0);
		drive_cycle(1'b0, column_ram_pkg::addr_t'(900), '0,
			1'b0, column_ram_pkg::addr_t'(901), '0);
		drive_cycle(1'b0, column_ram_pkg::addr_t'(901), '0,
			1'b0, column_ram_pkg::addr_t'(900), '0);
		report_test(6, "lane index pattern");

		$display("tests run: %0d, clean: %0d, with failures: %0d, assertion failures: %0d",
			test_count, tests_clean, tests_dirty, fails_seen);
		if (tests_dirty == 0 && tests_clean == test_count) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

//--- column_ram_pkg.sv
package column_ram_pkg;

	// Message quantization
	localparam int quan_size = 4; // Bits per message

	// Lane layout across the banks
	localparam int check_parallelism = 85;
	localparam int lanes_per_bank    = 9;  // Lanes in one full bank word
	localparam int full_bank_num     = 9;
	localparam int frag_lanes        = 4;  // Leftover lanes past the full banks

	// First lane held by the fragment bank
	localparam int frag_lane_base = full_bank_num * lanes_per_bank;

	// Bank geometry
	localparam int ram_depth  = 1024;
	localparam int addr_width = $clog2(ram_depth);

	// One quantized message
	typedef logic [quan_size-1:0] msg_t;

	typedef logic [addr_width-1:0] addr_t;

	// Slot lanes_per_bank-1 of a bank word holds the lowest lane of the bank
	typedef msg_t [lanes_per_bank-1:0] full_word_t; // 36 bits
	typedef msg_t [frag_lanes-1:0]     frag_word_t; // 16 bits

	// Whole port with lane 0 in the lowest bits
	typedef msg_t [check_parallelism-1:0] lane_bus_t; // 340 bits

endpackage

//--- dp_ram_bank.sv
`timescale 1ns/10ps

module dp_ram_bank #(
	parameter type word_t = column_ram_pkg::full_word_t
) (
	input  logic   sys_clk,
	input  logic   rst_n,
	bank_port_if.ram port_a, // Check-node side
	bank_port_if.ram port_b  // Variable-node side
);

	word_t mem [column_ram_pkg::ram_depth];

	// Read pipeline whose first stage loads from the array
	word_t rd_a_q1;
	word_t rd_a_q2;
	word_t rd_b_q1;
	word_t rd_b_q2;

	// Either port may write on its enable
	// Same-address writes from both ports in one cycle are undefined
	always_ff @(posedge sys_clk) begin
		if (port_a.we) begin
			mem[port_a.addr] <= port_a.din;
		end
		if (port_b.we) begin
			mem[port_b.addr] <= port_b.din;
		end
	end

	// Port A read path
	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_a_q1 <= '0;
		end else if (!port_a.we) begin
			rd_a_q1 <= mem[port_a.addr]; // Old data if B writes here now
		end
	end

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_a_q2 <= '0;
		end else begin
			rd_a_q2 <= rd_a_q1; // Advances even while A writes
		end
	end

	// Port B read path
	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_b_q1 <= '0;
		end else if (!port_b.we) begin
			rd_b_q1 <= mem[port_b.addr];
		end
	end

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_b_q2 <= '0;
		end else begin
			rd_b_q2 <= rd_b_q1;
		end
	end

	// Output register drives the port directly
	assign port_a.dout = rd_a_q2;
	assign port_b.dout = rd_b_q2;

endmodule

//--- src.f
column_ram_pkg.sv
bank_port_if.sv
dp_ram_bank.sv
column_msg_ram.sv
column_msg_ram_asserts.sv
column_msg_ram_tb.sv
